//--- rtl/stb_mem_pkg.sv
`default_nettype none

// Widths and types for the LSU to data cache path
package stb_mem_pkg;

    localparam int ADDR_W = 32; // Byte address width
    localparam int DATA_W = 32; // Data word width
    localparam int SEL_W  = 4;  // One bit per byte lane

    // Byte address as seen by the cache
    typedef logic [ADDR_W-1:0] addr_t;

    // Store data or load return data
    typedef logic [DATA_W-1:0] data_t;

    // Lanes written by a store
    typedef logic [SEL_W-1:0] sel_t;

endpackage : stb_mem_pkg

`default_nettype wire

//--- rtl/stb_cfg_pkg.sv
`default_nettype none

// Buffer sizing and drain FSM encoding
package stb_cfg_pkg;

    localparam int STB_DEPTH = 4;                // Pending stores held
    localparam int PTR_W     = $clog2(STB_DEPTH); // Index width

    // FIFO read/write index
    typedef logic [PTR_W-1:0] ptr_t;

    // Occupancy 0..STB_DEPTH, needs the extra bit
    typedef logic [PTR_W:0] cnt_t;

    // Cache side state machine
    typedef enum logic [1:0] {
        IDLE   = 2'd0, // Nothing on the cache port
        DRAIN  = 2'd1, // Writing the head entry
        BYPASS = 2'd2  // Load going straight to the cache
    } drain_state_t;

endpackage : stb_cfg_pkg

`default_nettype wire

//--- rtl/stb_lsu_stage.sv
`timescale 1ns/1ps
`default_nettype none

// LSU side of the store buffer
// Sorts requests into stores and loads, writes stores into the FIFO
// and answers the LSU with stall and ack
module stb_lsu_stage (
    input  logic clk,
    input  logic arst_n,

    input  logic lsu_req,       // Held until ack
    input  logic lsu_w_en,      // High for stores
    input  logic dmem_sel_in,   // Request targets data memory

    input  logic full,          // From datapath
    input  logic dcache_ack,    // Cache transfer done
    input  logic bypass_active, // Drain FSM in BYPASS

    output logic push,          // Write store into FIFO
    output logic load_pending,  // Load waiting or in flight
    output logic lsu_stall,
    output logic lsu_ack
);

    logic is_store;     // Store request present
    logic is_load;      // Load request present
    logic store_ack_q;  // Ack for the store pushed last cycle
    logic load_done;    // Bypassed read finishing this cycle
    logic store_stall;
    logic load_stall;

    // Requests without dmem_sel are not ours
    assign is_store = lsu_req & lsu_w_en & dmem_sel_in;
    assign is_load  = lsu_req & ~lsu_w_en & dmem_sel_in;

    assign load_pending = is_load;

    // The LSU still holds the store during its ack cycle
    // so the ack cycle must not write it a second time
    assign push = is_store & ~full & ~store_ack_q;

    // One cycle ack after the write edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            store_ack_q <= 1'b0;
        end else begin
            store_ack_q <= push; // Registered, latency 1
        end
    end

    // Read data arrives with the cache ack
    assign load_done = is_load & bypass_active & dcache_ack;

    // Store waits while the buffer is full
    assign store_stall = is_store & full & ~store_ack_q;

    // Load waits from its first cycle until the cache answers
    assign load_stall = is_load & ~load_done;

    assign lsu_stall = store_stall | load_stall;

    // Store ack is registered, load ack is same cycle as dcache_ack
    assign lsu_ack = store_ack_q | load_done;

endmodule : stb_lsu_stage

`default_nettype wire

//--- rtl/stb_datapath.sv
`timescale 1ns/1ps
`default_nettype none

// Circular store FIFO plus the cache port address/data mux
module stb_datapath
    import stb_mem_pkg::*;
    import stb_cfg_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,

    input  addr_t lsu_addr,     // Store or load address
    input  data_t lsu_wdata,
    input  sel_t  lsu_sel,

    input  logic  push,         // From LSU stage
    input  logic  pop,          // From drain stage on cache ack
    input  logic  bypass_sel,   // Show LSU address instead of head

    output addr_t dcache_addr,
    output data_t dcache_wdata,
    output sel_t  dcache_sel,

    output logic  full,
    output logic  empty
);

    // Entry storage
    addr_t addr_mem [STB_DEPTH];
    data_t data_mem [STB_DEPTH];
    sel_t  sel_mem  [STB_DEPTH];

    ptr_t wr_ptr;   // Next free slot
    ptr_t rd_ptr;   // Oldest store
    cnt_t count;    // Entries held

    logic do_push;
    logic do_pop;

    // Guard against overflow and underflow
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // Payload written at the tail
    always_ff @(posedge clk) begin
        if (do_push) begin
            addr_mem[wr_ptr] <= lsu_addr;
            data_mem[wr_ptr] <= lsu_wdata;
            sel_mem[wr_ptr]  <= lsu_sel;
        end
    end

    // Pointers wrap at the last slot
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_t'(STB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(STB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, push and pop may coincide
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither
            endcase
        end
    end

    assign full  = (count == cnt_t'(STB_DEPTH));
    assign empty = (count == '0);

    // Bypassed load carries no write payload
    always_comb begin
        if (bypass_sel) begin
            dcache_addr  = lsu_addr;
            dcache_wdata = '0;
            dcache_sel   = '0;
        end else begin
            dcache_addr  = addr_mem[rd_ptr]; // Head entry
            dcache_wdata = data_mem[rd_ptr];
            dcache_sel   = sel_mem[rd_ptr];
        end
    end

endmodule : stb_datapath

`default_nettype wire

//--- rtl/stb_drain_stage.sv
`timescale 1ns/1ps
`default_nettype none

// Cache side FSM
// Writes buffered stores to the cache one at a time and runs a
// load straight through once the buffer has gone empty
module stb_drain_stage
    import stb_cfg_pkg::*;
(
    input  logic clk,
    input  logic arst_n,

    input  logic empty,         // No stores pending
    input  logic load_pending,  // LSU has a load waiting
    input  logic dcache_ack,    // One cycle pulse from cache

    output logic pop,           // Retire head entry
    output logic bypass_sel,    // To datapath mux
    output logic bypass_active, // To LSU stage
    output logic dcache_req,
    output logic dcache_w_en,
    output logic dmem_sel_out
);

    drain_state_t state_q;
    drain_state_t state_d;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Stores go first, a load only sees an empty buffer
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (!empty) begin
                    state_d = DRAIN;
                end else if (load_pending) begin
                    state_d = BYPASS;
                end
            end
            DRAIN: begin
                // Head entry written, idle one cycle
                if (dcache_ack) begin
                    state_d = IDLE;
                end
            end
            BYPASS: begin
                if (dcache_ack) begin
                    state_d = IDLE; // Read data went to the LSU
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // Request held from state entry until ack
    assign dcache_req   = (state_q != IDLE);
    assign dcache_w_en  = (state_q == DRAIN);
    assign dmem_sel_out = dcache_req;   // Always data memory

    // Head leaves the FIFO on the write ack
    assign pop = (state_q == DRAIN) & dcache_ack;

    // Same decode, two destinations
    assign bypass_sel    = (state_q == BYPASS);
    assign bypass_active = (state_q == BYPASS);

endmodule : stb_drain_stage

`default_nettype wire

//--- rtl/store_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

// Store buffer between LSU and data cache
module store_buffer_top
    import stb_mem_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,

    // From LSU
    input  addr_t lsu_addr,
    input  data_t lsu_wdata,
    input  sel_t  lsu_sel,
    input  logic  lsu_w_en,
    input  logic  lsu_req,
    input  logic  dmem_sel_in,

    // To LSU
    output logic  lsu_stall,
    output logic  lsu_ack,
    output data_t lsu_rdata,

    // To data cache
    output addr_t dcache_addr,
    output data_t dcache_wdata,
    output sel_t  dcache_sel,
    output logic  dcache_w_en,
    output logic  dcache_req,
    output logic  dmem_sel_out,
    output logic  stb_empty,

    // From data cache
    input  data_t dcache_rdata,
    input  logic  dcache_ack
);

    logic push;          // LSU stage to FIFO
    logic pop;           // Drain stage to FIFO
    logic full;
    logic empty;
    logic load_pending;
    logic bypass_sel;    // Mux select in datapath
    logic bypass_active; // Same decode for the LSU stage

    // Load data is not registered
    assign lsu_rdata = dcache_rdata;
    assign stb_empty = empty;

    stb_lsu_stage u_lsu_stage (
        .clk           (clk),
        .arst_n        (arst_n),
        .lsu_req       (lsu_req),
        .lsu_w_en      (lsu_w_en),
        .dmem_sel_in   (dmem_sel_in),
        .full          (full),
        .dcache_ack    (dcache_ack),
        .bypass_active (bypass_active),
        .push          (push),
        .load_pending  (load_pending),
        .lsu_stall     (lsu_stall),
        .lsu_ack       (lsu_ack)
    );

    stb_datapath u_datapath (
        .clk          (clk),
        .arst_n       (arst_n),
        .lsu_addr     (lsu_addr),
        .lsu_wdata    (lsu_wdata),
        .lsu_sel      (lsu_sel),
        .push         (push),
        .pop          (pop),
        .bypass_sel   (bypass_sel),
        .dcache_addr  (dcache_addr),
        .dcache_wdata (dcache_wdata),
        .dcache_sel   (dcache_sel),
        .full         (full),
        .empty        (empty)
    );

    stb_drain_stage u_drain_stage (
        .clk           (clk),
        .arst_n        (arst_n),
        .empty         (empty),
        .load_pending  (load_pending),
        .dcache_ack    (dcache_ack),
        .pop           (pop),
        .bypass_sel    (bypass_sel),
        .bypass_active (bypass_active),
        .dcache_req    (dcache_req),
        .dcache_w_en   (dcache_w_en),
        .dmem_sel_out  (dmem_sel_out)
    );

endmodule : store_buffer_top

`default_nettype wire

//--- dv/store_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for the store buffer
// Ops come from the test data file, a cache model acks after a random wait
module store_buffer_tb
    import stb_mem_pkg::*;
    import stb_cfg_pkg::*;
();

    logic  clk = 1'b0;
    logic  arst_n;
    addr_t lsu_addr;
    data_t lsu_wdata;
    sel_t  lsu_sel;
    logic  lsu_w_en;
    logic  lsu_req;
    logic  dmem_sel_in;
    logic  lsu_stall;
    logic  lsu_ack;
    data_t lsu_rdata;
    addr_t dcache_addr;
    data_t dcache_wdata;
    sel_t  dcache_sel;
    logic  dcache_w_en;
    logic  dcache_req;
    logic  dmem_sel_out;
    logic  stb_empty;
    data_t dcache_rdata = '0; // Cache model outputs
    logic  dcache_ack = 1'b0;

    // Operations as read from the file
    logic  td_store [$];
    addr_t td_addr  [$];
    data_t td_data  [$];
    sel_t  td_sel   [$];
    data_t td_rdata [$];

    // Scoreboard of accepted stores not yet written
    addr_t exp_addr_q [$];
    data_t exp_data_q [$];
    sel_t  exp_sel_q  [$];
    int    occ = 0;         // Model occupancy
    int    occ_pre = 0;     // Occupancy at the start of the sampled cycle
    logic  ack_due = 1'b0;  // Store written at the last edge, ack expected now

    data_t exp_rdata;       // Read data the cache returns for the current load
    logic  seeded = 1'b0;   // Cache model generator seeded
    logic  busy = 1'b0;     // Cache model has a request in hand
    int    delay_left = 0;
    int    cycle_cnt = 0;
    int    cycle_limit = 0; // Set once the ops are known

    store_buffer_top uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .lsu_addr     (lsu_addr),
        .lsu_wdata    (lsu_wdata),
        .lsu_sel      (lsu_sel),
        .lsu_w_en     (lsu_w_en),
        .lsu_req      (lsu_req),
        .dmem_sel_in  (dmem_sel_in),
        .lsu_stall    (lsu_stall),
        .lsu_ack      (lsu_ack),
        .lsu_rdata    (lsu_rdata),
        .dcache_addr  (dcache_addr),
        .dcache_wdata (dcache_wdata),
        .dcache_sel   (dcache_sel),
        .dcache_w_en  (dcache_w_en),
        .dcache_req   (dcache_req),
        .dmem_sel_out (dmem_sel_out),
        .stb_empty    (stb_empty),
        .dcache_rdata (dcache_rdata),
        .dcache_ack   (dcache_ack)
    );

    always #5 clk = ~clk; // 10 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_sel(input string name, input sel_t exp, input sel_t act);
        if (act !== exp) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s expected %b actual %b", name, exp, act);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    // Comment lines start with //, blank lines skipped
    task automatic read_testdata();
        int    fd;
        int    n;
        int    kind;
        string line;
        addr_t a;
        data_t d;
        sel_t  s;
        data_t r;
        fd = $fopen("dv/store_buffer_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open dv/store_buffer_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n == 0 || line.substr(0, 1) == "//") continue;
                n = $sscanf(line, "%h %h %h %h %h", kind, a, d, s, r);
                if (n == 5) begin
                    td_store.push_back(kind != 0);
                    td_addr.push_back(a);
                    td_data.push_back(d);
                    td_sel.push_back(s);
                    td_rdata.push_back(r);
                end else if (line.len() > 1) begin
                    abort_run($sformatf("Test data line not understood: %s", line));
                end
            end
            $fclose(fd);
        end
    endtask

    // Present one request and hold it until the DUT acks
    task automatic issue_op(input int i);
        @(posedge clk);
        lsu_req     <= 1'b1;
        dmem_sel_in <= 1'b1;
        lsu_w_en    <= td_store[i];
        lsu_addr    <= td_addr[i];
        lsu_wdata   <= td_data[i];
        lsu_sel     <= td_sel[i];
        exp_rdata   <= td_rdata[i];
        @(negedge clk);
        while (!lsu_ack) @(negedge clk);
    endtask

    // Cache model, 0 to 5 wait cycles before each ack
    always @(posedge clk or negedge arst_n) begin
        if (!seeded) begin
            void'($urandom(89)); // Generator that draws the delays
            seeded = 1'b1;
        end
        if (!arst_n) begin
            dcache_ack   <= 1'b0;
            dcache_rdata <= '0;
            busy         <= 1'b0;
            delay_left   <= 0;
        end else if (dcache_ack) begin
            dcache_ack   <= 1'b0; // One cycle pulse
            dcache_rdata <= '0;
            busy         <= 1'b0;
        end else if (dcache_req) begin
            if (!busy) begin
                busy       <= 1'b1;
                delay_left <= $urandom % 6;
            end else if (delay_left == 0) begin
                dcache_ack   <= 1'b1;
                dcache_rdata <= dcache_w_en ? '0 : exp_rdata;
            end else begin
                delay_left <= delay_left - 1;
            end
        end
    end

    // Monitor and scoreboard, sampled mid cycle
    always @(negedge clk) begin
        if (arst_n) begin
            occ_pre = occ; // Entries the DUT holds this cycle
            if (dcache_req) begin
                check_bit("dmem_sel_out", 1'b1, dmem_sel_out);
                if (dcache_w_en && dcache_ack) begin
                    if (exp_addr_q.size() == 0) begin
                        abort_run("Cache write seen with no accepted store outstanding");
                    end else begin
                        check_addr("store_addr", exp_addr_q.pop_front(), dcache_addr);
                        check_data("store_data", exp_data_q.pop_front(), dcache_wdata);
                        check_sel("store_sel", exp_sel_q.pop_front(), dcache_sel);
                        occ = occ - 1; // Entry freed
                    end
                end else if (!dcache_w_en) begin
                    // Bypassed read only once all older stores are out
                    check_bit("read_for_load", 1'b1, lsu_req & ~lsu_w_en);
                    check_bit("read_buffer_empty", 1'b1, stb_empty);
                    check_bit("read_after_stores", 1'b1, exp_addr_q.size() == 0);
                    check_addr("read_addr", lsu_addr, dcache_addr);
                end
            end else begin
                check_bit("dmem_sel_idle", 1'b0, dmem_sel_out);
            end
            if (lsu_req && lsu_w_en) begin
                check_bit("store_ack_latency", ack_due, lsu_ack);
                if (lsu_ack) begin
                    check_bit("store_ack_room", 1'b1, occ < STB_DEPTH);
                    exp_addr_q.push_back(lsu_addr);
                    exp_data_q.push_back(lsu_wdata);
                    exp_sel_q.push_back(lsu_sel);
                    occ = occ + 1;
                end else begin
                    check_bit("full_stall", occ_pre == STB_DEPTH, lsu_stall);
                end
            end else if (lsu_req) begin
                if (lsu_ack) begin
                    check_data("load_rdata", exp_rdata, lsu_rdata);
                    check_bit("load_ack_stall", 1'b0, lsu_stall);
                    check_bit("load_ack_cache", 1'b1, dcache_ack & dcache_req & ~dcache_w_en);
                end else begin
                    check_bit("load_stall", 1'b1, lsu_stall);
                end
            end else begin
                check_bit("idle_ack", 1'b0, lsu_ack);
                check_bit("idle_stall", 1'b0, lsu_stall);
            end
            // Store with room is written at the coming edge
            ack_due = lsu_req & lsu_w_en & ~lsu_ack & (occ_pre < STB_DEPTH);
        end
    end

    // Run limit scales with the number of ops
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
            $display("Result: FAILED");
            $fatal(1);
        end
    end

    initial begin
        int i;
        arst_n      <= 1'b0;
        lsu_req     <= 1'b0;
        lsu_w_en    <= 1'b0;
        dmem_sel_in <= 1'b0;
        lsu_addr    <= '0;
        lsu_wdata   <= '0;
        lsu_sel     <= '0;
        exp_rdata   <= '0;
        read_testdata();
        cycle_limit = td_store.size() * 16 + 100;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_bit("reset_dcache_req", 1'b0, dcache_req);
        check_bit("reset_dcache_w_en", 1'b0, dcache_w_en);
        check_bit("reset_dmem_sel_out", 1'b0, dmem_sel_out);
        check_bit("reset_lsu_ack", 1'b0, lsu_ack);
        check_bit("reset_lsu_stall", 1'b0, lsu_stall);
        check_bit("reset_stb_empty", 1'b1, stb_empty);
        for (i = 0; i < td_store.size(); i++) begin
            issue_op(i);
        end
        @(posedge clk);
        lsu_req     <= 1'b0;
        dmem_sel_in <= 1'b0;
        @(negedge clk);
        while (!stb_empty || dcache_req) @(negedge clk); // Trailing stores drain
        if (exp_addr_q.size() == 0 && occ == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("%0d accepted stores never reached the cache", exp_addr_q.size());
            $display("Result: FAILED");
            $fatal(1);
        end
    end

endmodule : store_buffer_tb

`default_nettype wire

//--- dv/store_buffer_testdata.txt
// kind (1 store, 0 load)  addr  data  sel  rdata returned by the cache, all hex
// Stores drain in order, a load waits for the buffer to empty
1 00001000 11111111 f 00000000
1 00001004 22222222 f 00000000
0 00001000 00000000 f a5a5a5a5
1 00002000 deadbeef 3 00000000
1 00002004 cafef00d c 00000000
1 00002008 01234567 1 00000000
1 0000200c 89abcdef 8 00000000
1 00002010 0badf00d f 00000000
1 00002014 feedface 6 00000000
1 00002018 13579bdf f 00000000
0 00002004 00000000 f 5a5a5a5a
0 00003000 00000000 f 0f0f0f0f
1 00003004 aaaa5555 f 00000000
0 00003008 00000000 f 12345678
1 00004000 00000001 1 00000000
1 00004001 00000200 2 00000000
1 00004002 00030000 4 00000000
1 00004003 04000000 8 00000000
1 00004004 ffffffff f 00000000
1 00004008 80000000 8 00000000
0 00004000 00000000 f 04030201
1 00005000 a1b2c3d4 f 00000000
1 00005004 e5f60718 c 00000000
1 00005008 293a4b5c 3 00000000
1 0000500c 6d7e8f90 f 00000000
1 00005010 0f1e2d3c f 00000000
1 00005014 4b5a6978 9 00000000
1 00005018 8796a5b4 f 00000000
1 0000501c c3d2e1f0 f 00000000
0 00005010 00000000 f ffff0000
0 00005014 00000000 f 0000ffff
1 00006000 76543210 f 00000000
0 00006000 00000000 f 76543210
1 00007ffc 5555aaaa f 00000000
1 00008000 c0ffee00 e 00000000
1 00008004 00c0ffee 7 00000000
0 00008008 00000000 f 87654321
1 0000800c 31415926 f 00000000

//--- store_buffer_top.f
rtl/stb_mem_pkg.sv
rtl/stb_cfg_pkg.sv
rtl/stb_lsu_stage.sv
rtl/stb_datapath.sv
rtl/stb_drain_stage.sv
rtl/store_buffer_top.sv
dv/store_buffer_tb.sv

//--- Makefile
TOP = store_buffer_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -f store_buffer_top.f \
		--top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
		echo "$$out"; \
		echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
